// ==== build.f ====
+incdir+rtl
rtl/csr_pkg.sv
rtl/csr_access.sv
rtl/trap_regs.sv
rtl/hart_counters.sv
rtl/irq_ctrl.sv
rtl/csr_bank.sv
verification/csr_bank_tb.sv

// ==== Bender.yml ====
package:
  name: csr_bank

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/csr_pkg.sv
      - rtl/csr_access.sv
      - rtl/trap_regs.sv
      - rtl/hart_counters.sv
      - rtl/irq_ctrl.sv
      - rtl/csr_bank.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/csr_bank_tb.sv

// ==== verification/csr_bank_tb.sv ====
// Self-checking testbench of the CSR block that build.f compiles with csr_bank_tb as top
`timescale 1ns/100ps
`default_nettype none

`include "csr_macros.svh"

module csr_bank_tb
    import csr_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 20;
    localparam int COUNT_SPAN     = 12; // Cycles between the two counter reads

    logic        clk;
    logic        reset_n;
    csr_req_t    csr_req;
    trap_req_t   trap_req;
    logic        killed;
    logic [31:0] irq;
    logic [31:0] irq_lines;             // Applied to irq on the next falling edge
    logic [31:0] rdata;
    logic        irq_pending;
    priv_e       priv;
    logic [31:0] mepc;
    logic [31:0] mtvec;

    logic [31:0] lfsr_state;
    logic [31:0] rd;                    // Read data sampled mid cycle
    int          errors;
    int          errors_at_start;
    int          tests_passed;
    int          tests_failed;

    csr_bank i_dut (
        .clk           (clk),
        .reset_n       (reset_n),
        .csr_req_i     (csr_req),
        .trap_req_i    (trap_req),
        .killed_i      (killed),
        .irq_i         (irq),
        .rdata_o       (rdata),
        .irq_pending_o (irq_pending),
        .priv_o        (priv),
        .mepc_o        (mepc),
        .mtvec_o       (mtvec)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////
    // Helpers
    ////////////////////

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    task automatic run_cycle(input csr_req_t r, input trap_req_t t, input logic kill);
        @(negedge clk);
        csr_req  = r;
        trap_req = t;
        killed   = kill;
        irq      = irq_lines;
        #1;
        rd = rdata;
    endtask

    task automatic idle(input logic kill);
        run_cycle('0, '0, kill);
    endtask

    task automatic csr_read(input logic [11:0] addr, output logic [31:0] val);
        csr_req_t r;
        r      = '0;
        r.read = 1'b1;
        r.addr = addr;
        run_cycle(r, '0, 1'b0);
        val = rd;
    endtask

    task automatic csr_write(input logic [11:0] addr, input csr_op_e op,
                             input logic [31:0] data, input logic kill);
        csr_req_t r;
        r = '{read: 1'b1, write: 1'b1, op: op, addr: addr, data: data};
        run_cycle(r, '0, kill);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        a_value: assert (got === exp)
            else begin
                errors++;
                $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            end
    endtask

    task automatic expect_csr(input string what, input logic [11:0] addr,
                              input logic [31:0] exp);
        logic [31:0] val;
        csr_read(addr, val);
        check_value(what, val, exp);
    endtask

    task automatic wait_pending(input string what);
        int n;
        n = 0;
        while (!irq_pending && n < TIMEOUT_CYCLES) begin
            idle(1'b0);
            n++;
        end
        if (!irq_pending) begin
            errors++;
            $display("Timeout: irq_pending_o did not rise %s within %0d cycles",
                     what, TIMEOUT_CYCLES);
        end
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    ////////////////////
    // Protocol checks
    ////////////////////

    a_ack_drops_pending: assert property (
        @(posedge clk) disable iff (!reset_n)
        trap_req.irq_ack |=> !irq_pending
    ) else begin
        errors++;
        $display("[ERROR] %0t ns: irq_pending_o high the cycle after an ack", $time);
    end

    // Exception always lands in machine mode with mepc on the faulting pc
    a_exc_entry: assert property (
        @(posedge clk) disable iff (!reset_n)
        trap_req.raise_exception |=> (priv == PRIV_MACHINE && mepc == $past(trap_req.pc))
    ) else begin
        errors++;
        $display("[ERROR] %0t ns: priv_o or mepc_o wrong after exception", $time);
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        logic [11:0] addrs [4];
        logic [31:0] mask  [4];
        logic [31:0] model [4];
        logic [31:0] val;
        logic [31:0] data;
        logic [31:0] exp;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] target;
        logic [31:0] c0;
        logic [31:0] c1;
        logic [31:0] i0;
        logic [31:0] i1;
        trap_req_t   t;
        csr_op_e     op;
        int          idx;
        int          kills;

        lfsr_state      = 32'h4f17;
        errors          = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        reset_n         = 1'b0;
        csr_req         = '0;
        trap_req        = '0;
        killed          = 1'b0;
        irq             = '0;
        irq_lines       = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // Reset state
        expect_csr("mstatus", MSTATUS, '0);
        expect_csr("mie", MIE, '0);
        expect_csr("mepc", MEPC, '0);
        expect_csr("mcause", MCAUSE, '0);
        expect_csr("mtval", MTVAL, '0);
        expect_csr("misa", MISA, `CSR_MISA_VALUE);
        for (int a = 'hF11; a <= 'hF15; a++) begin
            expect_csr("identity register", a[11:0], '0);
        end
        check_value("priv_o", {30'b0, priv}, {30'b0, PRIV_MACHINE});
        check_value("irq_pending_o", {31'b0, irq_pending}, '0);
        end_test("reset state");

        // Masked access
        addrs = '{MSCRATCH, MTVEC, MIE, MSTATUS};
        mask  = '{32'hFFFF_FFFF, `CSR_ALIGN_WMASK, `CSR_MIE_WMASK, `CSR_MSTATUS_WMASK};
        model = '{default: '0};
        for (int k = 0; k < 32; k++) begin
            idx  = rand_bits(2);
            data = rand_bits(32);
            case (rand_bits(2) % 3)
                0: begin
                    op  = OP_WRITE;
                    exp = (model[idx] & ~mask[idx]) | (data & mask[idx]);
                end
                1: begin
                    op  = OP_SET;
                    exp = model[idx] | (data & mask[idx]);
                end
                default: begin
                    op  = OP_CLEAR;
                    exp = model[idx] & ~(data & mask[idx]);
                end
            endcase
            csr_write(addrs[idx], op, data, 1'b0);
            model[idx] = exp;
            expect_csr("masked access", addrs[idx], exp);
        end
        check_value("mtvec_o", mtvec, model[1]);
        csr_write(MSCRATCH, OP_WRITE, rand_bits(32), 1'b1);
        check_value("killed access read", rd, '0);
        expect_csr("mscratch after killed write", MSCRATCH, model[0]);
        expect_csr("unmapped address", 12'h7C0, '0);
        end_test("masked access");

        // Exception entry with MIE on and MPP user beforehand
        csr_write(MSTATUS, OP_WRITE, 32'h0000_0008, 1'b0);
        pc    = rand_bits(32) & ~32'h3;
        instr = rand_bits(32);
        t = '0;
        t.raise_exception = 1'b1;
        t.exc_code        = EXC_ILLEGAL_INSTR;
        t.pc              = pc;
        t.instr           = instr;
        run_cycle('0, t, 1'b0);
        expect_csr("mcause", MCAUSE, 32'd2);
        expect_csr("mepc", MEPC, pc);
        expect_csr("mtval on illegal instruction", MTVAL, instr);
        expect_csr("mstatus after trap", MSTATUS, 32'h0000_1880); // MPIE 1 and MPP machine
        check_value("mepc_o", mepc, pc);
        pc          = rand_bits(32) & ~32'h3;
        t.exc_code  = EXC_LOAD_ACCESS_FAULT;
        t.pc        = pc;
        run_cycle('0, t, 1'b0);
        expect_csr("mcause", MCAUSE, 32'd5);
        expect_csr("mtval on other code", MTVAL, pc);
        expect_csr("mstatus after second trap", MSTATUS, 32'h0000_1800);
        check_value("mepc_o", mepc, pc);
        end_test("exception entry");

        // Machine return to user
        csr_write(MSTATUS, OP_WRITE, 32'h0000_0080, 1'b0);
        t      = '0;
        t.mret = 1'b1;
        run_cycle('0, t, 1'b0);
        csr_read(MSTATUS, val);
        check_value("mstatus MIE after mret", {31'b0, val[`CSR_MSTATUS_MIE_BIT]}, 32'd1);
        check_value("priv_o after mret", {30'b0, priv}, {30'b0, PRIV_USER});
        end_test("machine return");

        // Interrupts
        csr_write(MIE, OP_WRITE, `CSR_MIE_WMASK, 1'b0);
        irq_lines = 32'h0000_0888;           // External, timer and software at once
        wait_pending("with three lines raised");
        target = rand_bits(32) & ~32'h3;
        t = '0;
        t.irq_ack     = 1'b1;
        t.jump        = 1'b1;
        t.jump_target = target;
        t.pc          = rand_bits(32) & ~32'h3;
        run_cycle('0, t, 1'b0);
        expect_csr("mcause external", MCAUSE, 32'h8000_000B);
        check_value("irq_pending_o after ack", {31'b0, irq_pending}, '0);
        expect_csr("mepc on jump", MEPC, target);
        irq_lines = 32'h0000_0088;
        t      = '0;
        t.mret = 1'b1;                        // Restores MIE from the stack
        run_cycle('0, t, 1'b0);
        wait_pending("with software and timer lines");
        pc = rand_bits(32) & ~32'h3;
        t = '0;
        t.irq_ack = 1'b1;
        t.pc      = pc;
        run_cycle('0, t, 1'b0);
        expect_csr("mcause software", MCAUSE, 32'h8000_0003);
        check_value("irq_pending_o after ack", {31'b0, irq_pending}, '0);
        expect_csr("mepc without jump", MEPC, pc + 32'd4);
        irq_lines = '0;
        end_test("interrupts");

        // Counters
        csr_read(MCYCLE, c0);
        csr_read(MINSTRET, i0);
        kills = 0;
        for (int k = 0; k < COUNT_SPAN - 2; k++) begin
            data  = rand_bits(1);
            kills += data[0];
            idle(data[0]);
        end
        csr_read(MCYCLE, c1);
        csr_read(MINSTRET, i1);
        check_value("mcycle difference", c1 - c0, COUNT_SPAN);
        check_value("minstret difference", i1 - i0, COUNT_SPAN - kills);
        data = rand_bits(32);
        csr_write(MCYCLEH, OP_WRITE, data, 1'b0);
        expect_csr("mcycleh readback", MCYCLEH, data);
        end_test("counters");

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/csr_bank.sv ====
// Top of the machine-mode CSR block, connects access decode, trap registers, counters and interrupts
`timescale 1ns/100ps
`default_nettype none

`include "csr_macros.svh"

module csr_bank
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  csr_req_t    csr_req_i,
    input  trap_req_t   trap_req_i,
    input  logic        killed_i,
    input  logic [31:0] irq_i,
    output logic [31:0] rdata_o,
    output logic        irq_pending_o,
    output priv_e       priv_o,
    output logic [31:0] mepc_o,
    output logic [31:0] mtvec_o
);

    csr_wr_t     csr_wr;
    trap_state_t trap_state;
    logic [31:0] mip;
    logic [63:0] mcycle;
    logic [63:0] minstret;
    irq_code_e   irq_code;

    ////////////////////
    // Units
    ////////////////////

    csr_access i_csr_access (
        .req_i      (csr_req_i),
        .killed_i   (killed_i),
        .state_i    (trap_state),
        .mip_i      (mip),
        .mcycle_i   (mcycle),
        .minstret_i (minstret),
        .wr_o       (csr_wr),
        .rdata_o    (rdata_o)
    );

    trap_regs i_trap_regs (
        .clk        (clk),
        .reset_n    (reset_n),
        .wr_i       (csr_wr),
        .trap_i     (trap_req_i),
        .irq_code_i (irq_code),
        .state_o    (trap_state)
    );

    hart_counters i_hart_counters (
        .clk        (clk),
        .reset_n    (reset_n),
        .wr_i       (csr_wr),
        .killed_i   (killed_i),
        .mcycle_o   (mcycle),
        .minstret_o (minstret)
    );

    irq_ctrl i_irq_ctrl (
        .clk           (clk),
        .reset_n       (reset_n),
        .irq_i         (irq_i),
        .mstatus_mie_i (trap_state.mstatus[`CSR_MSTATUS_MIE_BIT]), // Global enable
        .mie_i         (trap_state.mie),
        .irq_ack_i     (trap_req_i.irq_ack),
        .mip_o         (mip),
        .pending_o     (irq_pending_o),
        .irq_code_o    (irq_code)
    );

    // Pipeline facing views of the trap state
    assign priv_o  = trap_state.priv;
    assign mepc_o  = trap_state.mepc;
    assign mtvec_o = trap_state.mtvec;

endmodule

`default_nettype wire

// ==== rtl/irq_ctrl.sv ====
// Samples interrupt lines into mip and flags the highest priority enabled interrupt, in csr_bank
`timescale 1ns/100ps
`default_nettype none

module irq_ctrl
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic [31:0] irq_i,
    input  logic        mstatus_mie_i,
    input  logic [31:0] mie_i,
    input  logic        irq_ack_i,
    output logic [31:0] mip_o,
    output logic        pending_o,
    output irq_code_e   irq_code_o
);

    logic [31:0] mip_q;
    logic [31:0] active;

    assign active = mip_q & mie_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mip_q     <= '0;
            pending_o <= 1'b0;
        end else begin
            mip_q     <= irq_i;
            pending_o <= mstatus_mie_i && (active != '0) && !irq_ack_i;
        end
    end

    // Code holds its last value while nothing is pending
    always_ff @(posedge clk) begin
        if (active[IRQ_M_EXT]) begin
            irq_code_o <= IRQ_M_EXT;
        end else if (active[IRQ_M_SW]) begin
            irq_code_o <= IRQ_M_SW;
        end else if (active[IRQ_M_TIM]) begin
            irq_code_o <= IRQ_M_TIM;
        end
    end

    assign mip_o = mip_q;

    // An acked interrupt must not be taken twice
    a_no_pend_after_ack: assert property (
        @(posedge clk) disable iff (!reset_n)
        irq_ack_i |=> !pending_o
    ) else $error("Interrupt still pending the cycle after ack");

endmodule

`default_nettype wire

// ==== rtl/hart_counters.sv ====
// Free running mcycle and minstret counters with 32-bit half writes, instantiated in csr_bank
`timescale 1ns/100ps
`default_nettype none

module hart_counters
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  csr_wr_t     wr_i,
    input  logic        killed_i,
    output logic [63:0] mcycle_o,
    output logic [63:0] minstret_o
);

    logic [63:0] mcycle_q;
    logic [63:0] minstret_q;
    csr_addr_e   csr;

    assign csr = csr_addr_e'(wr_i.addr);

    // Increment first, a half write then overrides its own word
    function automatic logic [63:0] next_count(
        input logic [63:0] cur,
        input logic        inc,
        input logic        wr_lo,
        input logic        wr_hi,
        input logic [31:0] data
    );
        logic [63:0] result;
        result = cur + {63'b0, inc};
        if (wr_lo) begin
            result[31:0] = data;
        end
        if (wr_hi) begin
            result[63:32] = data;
        end
        return result;
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            mcycle_q   <= next_count(mcycle_q, 1'b1,
                                     wr_i.en && (csr == MCYCLE),
                                     wr_i.en && (csr == MCYCLEH), wr_i.data);
            minstret_q <= next_count(minstret_q, !killed_i,
                                     wr_i.en && (csr == MINSTRET),
                                     wr_i.en && (csr == MINSTRETH), wr_i.data);
        end
    end

    assign mcycle_o   = mcycle_q;
    assign minstret_o = minstret_q;

endmodule

`default_nettype wire

// ==== rtl/trap_regs.sv ====
// Machine trap CSRs and privilege level with exception, interrupt and mret handling, in csr_bank
`timescale 1ns/100ps
`default_nettype none

`include "csr_macros.svh"

module trap_regs
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  csr_wr_t     wr_i,
    input  trap_req_t   trap_i,
    input  irq_code_e   irq_code_i,
    output trap_state_t state_o
);

    trap_state_t state_q;
    logic [1:0]  mpp;
    logic        take_trap;

    assign mpp       = state_q.mstatus[`CSR_MSTATUS_MPP_LSB +: 2];
    assign take_trap = trap_i.raise_exception || trap_i.irq_ack;
    assign state_o   = state_q;

    // Push the interrupt enable stack and record the previous privilege
    function automatic logic [31:0] push_status(input logic [31:0] status, input priv_e priv);
        logic [31:0] result;
        result = status;
        result[`CSR_MSTATUS_MPIE_BIT]    = status[`CSR_MSTATUS_MIE_BIT];
        result[`CSR_MSTATUS_MIE_BIT]     = 1'b0;
        result[`CSR_MSTATUS_MPP_LSB +: 2] = priv;
        return result;
    endfunction

    ////////////////////
    // Register update
    ////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q.mstatus  <= '0;
            state_q.mie      <= '0;
            state_q.mtvec    <= '0;
            state_q.mscratch <= '0;
            state_q.mepc     <= '0;
            state_q.mcause   <= '0;
            state_q.mtval    <= '0;
            state_q.priv     <= PRIV_MACHINE;
        end else if (trap_i.mret) begin
            state_q.mstatus[`CSR_MSTATUS_MIE_BIT] <= state_q.mstatus[`CSR_MSTATUS_MPIE_BIT];
            // MPP may hold an unsupported level, anything but machine drops to user
            state_q.priv <= (mpp == PRIV_MACHINE) ? PRIV_MACHINE : PRIV_USER;
        end else if (take_trap) begin
            state_q.mstatus <= push_status(state_q.mstatus, state_q.priv);
            state_q.priv    <= PRIV_MACHINE;
            if (trap_i.raise_exception) begin
                state_q.mcause <= {27'b0, trap_i.exc_code};
                state_q.mepc   <= trap_i.pc;
                state_q.mtval  <= (trap_i.exc_code == EXC_ILLEGAL_INSTR) ? trap_i.instr
                                                                         : trap_i.pc;
            end else begin
                state_q.mcause <= {1'b1, 26'b0, irq_code_i};
                // Current instruction retires, resume after it
                state_q.mepc   <= trap_i.jump ? trap_i.jump_target : trap_i.pc + 32'd4;
            end
        end else if (wr_i.en) begin
            case (csr_addr_e'(wr_i.addr))
                MSTATUS:  state_q.mstatus  <= wr_i.data;
                MIE:      state_q.mie      <= wr_i.data;
                MTVEC:    state_q.mtvec    <= wr_i.data;
                MSCRATCH: state_q.mscratch <= wr_i.data;
                MEPC:     state_q.mepc     <= wr_i.data;
                MCAUSE:   state_q.mcause   <= wr_i.data;
                MTVAL:    state_q.mtval    <= wr_i.data;
                default: ; // Counter writes, handled in hart_counters
            endcase
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // The pipeline resolves mret and exceptions in one stage, never both at once
    a_exc_mret_excl: assert property (
        @(posedge clk) disable iff (!reset_n)
        !(trap_i.raise_exception && trap_i.mret)
    ) else $error("raise_exception and mret asserted together");

endmodule

`default_nettype wire

// ==== rtl/csr_access.sv ====
// Address decode, masked read-modify-write and read mux of the CSR block, used inside csr_bank
`timescale 1ns/100ps
`default_nettype none

`include "csr_macros.svh"

module csr_access
    import csr_pkg::*;
(
    input  csr_req_t    req_i,
    input  logic        killed_i,
    input  trap_state_t state_i,
    input  logic [31:0] mip_i,
    input  logic [63:0] mcycle_i,
    input  logic [63:0] minstret_i,
    output csr_wr_t     wr_o,
    output logic [31:0] rdata_o
);

    csr_addr_e   csr;
    logic [31:0] cur_val;
    logic [31:0] wmask;
    logic [31:0] new_val;
    logic        mapped;
    logic        access_ok;

    assign csr       = csr_addr_e'(req_i.addr);
    assign access_ok = !killed_i;

    ////////////////////
    // Decode
    ////////////////////

    always_comb begin
        cur_val = '0;
        wmask   = '0;
        mapped  = 1'b1;
        case (csr)
            MSTATUS: begin
                cur_val = state_i.mstatus;
                wmask   = `CSR_MSTATUS_WMASK;
            end
            MISA:     cur_val = `CSR_MISA_VALUE; // Fixed, writes ignored
            MIE: begin
                cur_val = state_i.mie;
                wmask   = `CSR_MIE_WMASK;
            end
            MTVEC: begin
                cur_val = state_i.mtvec;
                wmask   = `CSR_ALIGN_WMASK;
            end
            MSCRATCH: begin
                cur_val = state_i.mscratch;
                wmask   = '1;
            end
            MEPC: begin
                cur_val = state_i.mepc;
                wmask   = `CSR_ALIGN_WMASK;
            end
            MCAUSE: begin
                cur_val = state_i.mcause;
                wmask   = '1;
            end
            MTVAL: begin
                cur_val = state_i.mtval;
                wmask   = '1;
            end
            MIP:      cur_val = mip_i;         // Follows the irq lines
            MCYCLE: begin
                cur_val = mcycle_i[31:0];
                wmask   = '1;
            end
            MCYCLEH: begin
                cur_val = mcycle_i[63:32];
                wmask   = '1;
            end
            MINSTRET: begin
                cur_val = minstret_i[31:0];
                wmask   = '1;
            end
            MINSTRETH: begin
                cur_val = minstret_i[63:32];
                wmask   = '1;
            end
            // User aliases, read only
            CYCLE:    cur_val = mcycle_i[31:0];
            CYCLEH:   cur_val = mcycle_i[63:32];
            INSTRET:  cur_val = minstret_i[31:0];
            INSTRETH: cur_val = minstret_i[63:32];
            MVENDORID, MARCHID, MIMPID, MHARTID, MCONFIGPTR: cur_val = '0;
            default:  mapped = 1'b0;
        endcase
    end

    ////////////////////
    // Operation
    ////////////////////

    always_comb begin
        case (req_i.op)
            OP_SET:   new_val = cur_val | (req_i.data & wmask);
            OP_CLEAR: new_val = cur_val & ~(req_i.data & wmask);
            default:  new_val = (cur_val & ~wmask) | (req_i.data & wmask);
        endcase
    end

    // Registers without writable bits never see an enable
    assign wr_o.en   = req_i.write && access_ok && (wmask != '0);
    assign wr_o.addr = req_i.addr;
    assign wr_o.data = new_val;

    assign rdata_o = (req_i.read && access_ok && mapped) ? cur_val : '0;

    // Write decode must agree with the read map shared with trap_regs and hart_counters
    always_comb begin
        if (wr_o.en) begin
            a_wr_mapped: assert final (mapped)
                else $error("CSR write enabled for unmapped address %h", req_i.addr);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/csr_pkg.sv ====
// Types shared by the CSR block units, imported by wildcard into each module header
`default_nettype none

`include "csr_macros.svh"

package csr_pkg;

    // CSR addresses that the block keeps
    typedef enum logic [`CSR_ADDR_W-1:0] {
        MSTATUS    = 12'h300,
        MISA       = 12'h301,
        MIE        = 12'h304,
        MTVEC      = 12'h305,
        MSCRATCH   = 12'h340,
        MEPC       = 12'h341,
        MCAUSE     = 12'h342,
        MTVAL      = 12'h343,
        MIP        = 12'h344,
        MCYCLE     = 12'hB00,
        MINSTRET   = 12'hB02,
        MCYCLEH    = 12'hB80,
        MINSTRETH  = 12'hB82,
        CYCLE      = 12'hC00,
        INSTRET    = 12'hC02,
        CYCLEH     = 12'hC80,
        INSTRETH   = 12'hC82,
        MVENDORID  = 12'hF11,
        MARCHID    = 12'hF12,
        MIMPID     = 12'hF13,
        MHARTID    = 12'hF14,
        MCONFIGPTR = 12'hF15
    } csr_addr_e;

    typedef enum logic [1:0] {
        OP_WRITE = 2'd0,
        OP_SET   = 2'd1,
        OP_CLEAR = 2'd2
    } csr_op_e;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_e;

    typedef enum logic [4:0] {
        EXC_INSTR_MISALIGNED   = 5'd0,
        EXC_INSTR_ACCESS_FAULT = 5'd1,
        EXC_ILLEGAL_INSTR      = 5'd2,
        EXC_BREAKPOINT         = 5'd3,
        EXC_LOAD_MISALIGNED    = 5'd4,
        EXC_LOAD_ACCESS_FAULT  = 5'd5,
        EXC_STORE_MISALIGNED   = 5'd6,
        EXC_STORE_ACCESS_FAULT = 5'd7,
        EXC_ECALL_U            = 5'd8,
        EXC_ECALL_M            = 5'd11
    } exc_code_e;

    typedef enum logic [4:0] {
        IRQ_M_SW  = 5'd3,
        IRQ_M_TIM = 5'd7,
        IRQ_M_EXT = 5'd11
    } irq_code_e;

    // Access from the pipeline, addr kept raw so unmapped values pass through
    typedef struct packed {
        logic                   read;
        logic                   write;
        csr_op_e                op;
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`CSR_XLEN-1:0]   data;
    } csr_req_t;

    typedef struct packed {
        logic                 raise_exception;
        exc_code_e            exc_code;
        logic                 mret;
        logic                 irq_ack;
        logic                 jump;
        logic [`CSR_XLEN-1:0] pc;
        logic [`CSR_XLEN-1:0] instr;
        logic [`CSR_XLEN-1:0] jump_target;
    } trap_req_t;

    // Resolved write, data already merged with the masked old value
    typedef struct packed {
        logic                   en;
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`CSR_XLEN-1:0]   data;
    } csr_wr_t;

    typedef struct packed {
        logic [`CSR_XLEN-1:0] mstatus;
        logic [`CSR_XLEN-1:0] mie;
        logic [`CSR_XLEN-1:0] mtvec;
        logic [`CSR_XLEN-1:0] mscratch;
        logic [`CSR_XLEN-1:0] mepc;
        logic [`CSR_XLEN-1:0] mcause;
        logic [`CSR_XLEN-1:0] mtval;
        priv_e                priv;
    } trap_state_t;

endpackage

`default_nettype wire

// ==== rtl/csr_macros.svh ====
// Widths, write masks and fixed values of the machine-mode CSR block, included by package and RTL
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

////////////////////
// Widths
////////////////////

`define CSR_XLEN   32
`define CSR_ADDR_W 12

////////////////////
// mstatus layout
////////////////////

`define CSR_MSTATUS_MIE_BIT  3
`define CSR_MSTATUS_MPIE_BIT 7
`define CSR_MSTATUS_MPP_LSB  11

////////////////////
// Write masks
////////////////////

// MIE, MPIE and MPP only
`define CSR_MSTATUS_WMASK 32'h0000_1888

`define CSR_MIE_WMASK     32'h0000_0888 // MSIE, MTIE, MEIE
`define CSR_ALIGN_WMASK   32'hFFFF_FFFC // Word aligned, mtvec and mepc

////////////////////
// Identity
////////////////////

// MXL 1 (XLEN 32), U and I extensions
`define CSR_MISA_VALUE 32'h4010_0100

`endif
